/* verilog/turbo_out_pkg.sv */
// widths, block geometry and shared bundles of the turbo decoder output stage
`default_nettype none

package turbo_out_pkg;

  // ------------------------------
  // block geometry
  // ------------------------------

  localparam int addr_w          = 6;                     // bit address inside one block
  localparam int rdat_w          = 2;                     // read word width
  localparam int tag_w           = 8;                     // block tag
  localparam int words_per_block = (2**addr_w) / rdat_w;  // 32 read words
  localparam int widx_w          = $clog2(words_per_block);
  localparam int sel_w           = $clog2(rdat_w);        // bit select inside a read word

  // ------------------------------
  // bundles
  // ------------------------------

  // decoder write request, both ports share one strobe
  typedef struct packed {
    logic              write;  // write strobe
    logic [addr_w-1:0] faddr;  // forward port, walks up from 0
    logic              fbit;
    logic [addr_w-1:0] baddr;  // backward port, walks down from 63
    logic              bbit;
  } wr_req_t;

  // framed output word
  typedef struct packed {
    logic              valid;
    logic              sop;    // first word of block
    logic              eop;    // last word of block
    logic [rdat_w-1:0] data;
    logic [tag_w-1:0]  tag;
  } out_word_t;

endpackage

`default_nettype wire

/* verilog/buffer_bank_ctrl.sv */
// bank pointers and full-bank counter of the nD output buffer
// status flags derived from the counter
`timescale 1ns/1ps
`default_nettype none

module buffer_bank_ctrl #(
  parameter int bnum_w = 1
) (
  input  logic              iclk,
  input  logic              reset,
  input  logic              iclkena,
  input  logic              wfull,    // writer closes a bank
  input  logic              rempty,   // reader frees a bank
  output logic [bnum_w-1:0] b_wused,  // bank being written
  output logic [bnum_w-1:0] b_rused,  // bank being read
  output logic              empty,
  output logic              emptya,
  output logic              full,
  output logic              fulla
);

  // ------------------------------
  // counter limits
  // ------------------------------

  // one bit wider than the pointers so N itself fits
  localparam logic [bnum_w:0] nbanks    = {1'b1, {bnum_w{1'b0}}};
  localparam logic [bnum_w:0] nbanks_m1 = nbanks - 1'b1;

  logic [bnum_w:0] cnt;  // banks full and waiting for the reader

  // ------------------------------
  // pointers and count
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      b_wused <= '0;
      b_rused <= '0;
      cnt     <= '0;
    end else if (iclkena) begin
      if (wfull) begin
        b_wused <= b_wused + 1'b1;  // wraps over N banks
      end
      if (rempty) begin
        b_rused <= b_rused + 1'b1;
      end
      // both at once leave the count alone
      case ({wfull, rempty})
        2'b10:   cnt <= cnt + 1'b1;
        2'b01:   cnt <= cnt - 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

  // ------------------------------
  // status flags
  // ------------------------------

  assign full   = (cnt == nbanks);
  assign fulla  = (cnt >= nbanks_m1);   // one free bank or less
  assign empty  = (cnt == '0);
  assign emptya = (cnt <= 1'b1);        // one full bank or less

endmodule

`default_nettype wire

/* verilog/dec_output_ram.sv */
// bit RAM, two 1-bit write ports, optional write pipeline stage
// registered read of rdat_w-bit words
`timescale 1ns/1ps
`default_nettype none

module dec_output_ram #(
  parameter int bnum_w = 1,
  parameter bit wpipe  = 0
) (
  input  logic                                          iclk,
  input  logic                                          reset,
  input  logic                                          iclkena,
  input  turbo_out_pkg::wr_req_t                        wr,
  input  logic [bnum_w-1:0]                             wbank,
  input  logic [bnum_w+turbo_out_pkg::widx_w-1:0]       raddr,  // {bank, word index}
  output logic [turbo_out_pkg::rdat_w-1:0]              rdata
);

  localparam int raw_w = bnum_w + turbo_out_pkg::widx_w;  // word address incl bank
  localparam int sel_w = turbo_out_pkg::sel_w;
  localparam int adr_w = turbo_out_pkg::addr_w;

  logic [turbo_out_pkg::rdat_w-1:0] mem [0:(2**raw_w)-1];

  turbo_out_pkg::wr_req_t wr_s;     // request as seen by the array
  logic [bnum_w-1:0]      wbank_s;

  // ------------------------------
  // write path stage
  // ------------------------------

  generate
    if (wpipe) begin : g_wpipe
      always_ff @(posedge iclk) begin
        if (iclkena) begin
          wr_s    <= wr;
          wbank_s <= wbank;  // bank travels with its data
        end
        if (reset) begin
          wr_s.write <= 1'b0;  // only the strobe is cleared
        end
      end
    end else begin : g_wdirect
      assign wr_s    = wr;
      assign wbank_s = wbank;
    end
  endgenerate

  // ------------------------------
  // array
  // ------------------------------

  logic [raw_w-1:0] fwa, bwa;    // word addresses
  logic [sel_w-1:0] fsel, bsel;  // bit inside word

  // bit a goes to word a/2, position a mod 2
  assign fwa  = {wbank_s, wr_s.faddr[adr_w-1:sel_w]};
  assign bwa  = {wbank_s, wr_s.baddr[adr_w-1:sel_w]};
  assign fsel = wr_s.faddr[sel_w-1:0];
  assign bsel = wr_s.baddr[sel_w-1:0];

  always_ff @(posedge iclk) begin
    if (iclkena) begin
      if (wr_s.write) begin
        mem[fwa][fsel] <= wr_s.fbit;  // forward port
        mem[bwa][bsel] <= wr_s.bbit;  // backward port, other bit
      end
      rdata <= mem[raddr];  // 1 cycle read latency
    end
  end

endmodule

`default_nettype wire

/* verilog/turbo_dec_output_buffer.sv */
// nD output buffer: bank control, data RAM and per-bank tag memory
`timescale 1ns/1ps
`default_nettype none

module turbo_dec_output_buffer #(
  parameter int bnum_w = 1,
  parameter bit wpipe  = 0
) (
  input  logic                                 iclk,
  input  logic                                 reset,
  input  logic                                 iclkena,
  // decoder side
  input  turbo_out_pkg::wr_req_t               wr,
  input  logic                                 wfull,
  input  logic [turbo_out_pkg::tag_w-1:0]      wtag,
  // reader side
  input  logic                                 rempty,
  input  logic [turbo_out_pkg::widx_w-1:0]     raddr,
  output logic [turbo_out_pkg::rdat_w-1:0]     rdata,
  output logic [turbo_out_pkg::tag_w-1:0]      rtag,
  // status
  output logic                                 empty,
  output logic                                 emptya,
  output logic                                 full,
  output logic                                 fulla
);

  logic [bnum_w-1:0] b_wused;  // write bank
  logic [bnum_w-1:0] b_rused;  // read bank

  // ------------------------------
  // bank control
  // ------------------------------

  buffer_bank_ctrl #(
    .bnum_w (bnum_w)
  ) u_bank_ctrl (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .wfull   (wfull),
    .rempty  (rempty),
    .b_wused (b_wused),
    .b_rused (b_rused),
    .empty   (empty),
    .emptya  (emptya),
    .full    (full),
    .fulla   (fulla)
  );

  // ------------------------------
  // data ram
  // ------------------------------

  dec_output_ram #(
    .bnum_w (bnum_w),
    .wpipe  (wpipe)
  ) u_ram (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .wr      (wr),
    .wbank   (b_wused),
    .raddr   ({b_rused, raddr}),  // read bank on top
    .rdata   (rdata)
  );

  // ------------------------------
  // tag memory, one entry per bank
  // ------------------------------

  logic [turbo_out_pkg::tag_w-1:0] tag_mem [0:(2**bnum_w)-1];

  always_ff @(posedge iclk) begin
    if (iclkena && wfull) begin
      tag_mem[b_wused] <= wtag;  // stored as the bank closes
    end
  end

  assign rtag = tag_mem[b_rused];  // no read latency

endmodule

`default_nettype wire

/* verilog/block_reader.sv */
// block reader: drains one full bank as framed words, then frees it
`timescale 1ns/1ps
`default_nettype none

module block_reader (
  input  logic                                iclk,
  input  logic                                reset,
  input  logic                                iclkena,
  input  logic                                empty,
  input  logic                                pause,   // holds the drain
  input  logic [turbo_out_pkg::rdat_w-1:0]    rdata,
  input  logic [turbo_out_pkg::tag_w-1:0]     rtag,
  output logic [turbo_out_pkg::widx_w-1:0]    raddr,   // word index in read bank
  output logic                                rempty,  // frees the read bank
  output turbo_out_pkg::out_word_t            out
);

  typedef enum logic {st_idle, st_read} state_t;

  // words_per_block is a power of two, so the last index is all ones
  localparam logic [turbo_out_pkg::widx_w-1:0] last_widx = '1;

  state_t                               state;
  logic [turbo_out_pkg::widx_w-1:0]     widx;
  logic                                 issued;              // whole bank addressed
  logic                                 rd_en;
  logic                                 vld1, sop1, eop1;    // ram stage markers
  logic                                 out_v, out_sop, out_eop;
  logic [turbo_out_pkg::rdat_w-1:0]     out_data;
  logic [turbo_out_pkg::tag_w-1:0]      out_tag;
  logic                                 rempty_q;

  assign rd_en = (state == st_read) && !issued && !pause;
  assign raddr = widx;  // frozen while paused

  // ------------------------------
  // fsm and word counter
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      state  <= st_idle;
      widx   <= '0;
      issued <= 1'b0;
    end else if (iclkena) begin
      case (state)
        st_idle: begin
          if (!empty && !pause) begin
            state  <= st_read;
            widx   <= '0;
            issued <= 1'b0;
          end
        end
        st_read: begin
          if (rd_en) begin
            widx <= widx + 1'b1;
            if (widx == last_widx) issued <= 1'b1;
          end
          if (rempty_q) state <= st_idle;  // bank count updates with it
        end
        default: state <= st_idle;
      endcase
    end
  end

  // ------------------------------
  // framing, aligned to ram latency
  // ------------------------------

  always_ff @(posedge iclk) begin
    if (reset) begin
      vld1     <= 1'b0;
      sop1     <= 1'b0;
      eop1     <= 1'b0;
      out_v    <= 1'b0;
      out_sop  <= 1'b0;
      out_eop  <= 1'b0;
      rempty_q <= 1'b0;
    end else if (iclkena) begin
      vld1     <= rd_en;
      sop1     <= rd_en && (widx == '0);
      eop1     <= rd_en && (widx == last_widx);
      out_v    <= vld1;
      out_sop  <= sop1;
      out_eop  <= eop1;
      rempty_q <= out_v && out_eop;  // cycle after the eop word
    end
  end

  // payload, rdata valid together with vld1
  always_ff @(posedge iclk) begin
    if (iclkena) begin
      out_data <= rdata;
      out_tag  <= rtag;
    end
  end

  // held words show only on enabled cycles, so each counts once
  assign out = '{valid: out_v   & iclkena,
                 sop:   out_sop & iclkena,
                 eop:   out_eop & iclkena,
                 data:  out_data,
                 tag:   out_tag};

  assign rempty = rempty_q & iclkena;

endmodule

`default_nettype wire

/* verilog/turbo_out_top.sv */
// output stage top: nD buffer plus block reader
`timescale 1ns/1ps
`default_nettype none

module turbo_out_top #(
  parameter int bnum_w = 1,  // log2 of bank count
  parameter bit wpipe  = 0   // extra write stage
) (
  input  logic                              iclk,
  input  logic                              reset,
  input  logic                              iclkena,
  input  turbo_out_pkg::wr_req_t            wr,
  input  logic                              wfull,
  input  logic [turbo_out_pkg::tag_w-1:0]   wtag,
  input  logic                              pause,
  output turbo_out_pkg::out_word_t          out,
  output logic                              empty,
  output logic                              emptya,
  output logic                              full,
  output logic                              fulla
);

  logic [turbo_out_pkg::rdat_w-1:0] rdata;
  logic [turbo_out_pkg::tag_w-1:0]  rtag;
  logic [turbo_out_pkg::widx_w-1:0] raddr;
  logic                             rempty;

  turbo_dec_output_buffer #(
    .bnum_w (bnum_w),
    .wpipe  (wpipe)
  ) u_buffer (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .wr      (wr),
    .wfull   (wfull),
    .wtag    (wtag),
    .rempty  (rempty),
    .raddr   (raddr),
    .rdata   (rdata),
    .rtag    (rtag),
    .empty   (empty),
    .emptya  (emptya),
    .full    (full),
    .fulla   (fulla)
  );

  block_reader u_reader (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .empty   (empty),
    .pause   (pause),
    .rdata   (rdata),
    .rtag    (rtag),
    .raddr   (raddr),
    .rempty  (rempty),
    .out     (out)
  );

endmodule

`default_nettype wire

/* verif/turbo_out_assertions.sv */
// bound checks on bank flags, block framing and bank release
`timescale 1ns/1ps
`default_nettype none

module turbo_out_assertions (
  input logic iclk,
  input logic reset,
  input logic empty,
  input logic full,
  input logic rempty,
  input logic sop,
  input logic eop
);

  int fails = 0;  // count of failed checks

  // count cannot be 0 and N at once
  a_full_empty: assert property (@(posedge iclk) disable iff (reset) !(full && empty))
    else begin
      $error("bank count reports full and empty together");
      fails++;
    end

  // a block is 32 words, never one
  a_sop_eop: assert property (@(posedge iclk) disable iff (reset) !(sop && eop))
    else begin
      $error("start and end of block marked on the same word");
      fails++;
    end

  a_rempty: assert property (@(posedge iclk) disable iff (reset) rempty |-> !empty)
    else begin
      $error("bank freed while no bank is full");
      fails++;
    end

endmodule

`default_nettype wire

/* verif/tb_turbo_out.sv */
// testbench for the turbo decoder output stage
// block writer, reference packing, comparator, watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_turbo_out;

  localparam int bnum_w       = 1;
  localparam bit wpipe        = 0;
  localparam int nbanks       = 1 << bnum_w;
  localparam int nbits        = 2**turbo_out_pkg::addr_w;        // bits per block
  localparam int nwords       = turbo_out_pkg::words_per_block;
  localparam int total_blocks = 7 + 2 * nbanks;                  // blocks of tests 2 to 5
  localparam int wd_cycles    = 400 * total_blocks + 1000;
  localparam int drain_limit  = 3000;

  logic                            iclk;
  logic                            reset;
  logic                            iclkena;
  logic                            wfull;
  logic                            pause;
  logic [turbo_out_pkg::tag_w-1:0] wtag;
  turbo_out_pkg::wr_req_t          wr;
  turbo_out_pkg::out_word_t        out;
  logic                            empty;
  logic                            emptya;
  logic                            full;
  logic                            fulla;

  turbo_out_pkg::out_word_t exp_q[$];  // reference words in block order
  int   errors    = 0;
  int   checks    = 0;
  int   tests_run = 0;
  int   tests_ok  = 0;
  int   wcnt      = 0;   // words since sop
  int   frames    = 0;
  logic pause_d1  = 1'b0;
  logic pause_d2  = 1'b0;  // pause two enabled cycles back

  turbo_out_top #(
    .bnum_w (bnum_w),
    .wpipe  (wpipe)
  ) dut (
    .iclk    (iclk),
    .reset   (reset),
    .iclkena (iclkena),
    .wr      (wr),
    .wfull   (wfull),
    .wtag    (wtag),
    .pause   (pause),
    .out     (out),
    .empty   (empty),
    .emptya  (emptya),
    .full    (full),
    .fulla   (fulla)
  );

  bind block_reader turbo_out_assertions u_reader_chk (
    .iclk   (iclk),
    .reset  (reset),
    .empty  (empty),
    .full   (1'b0),
    .rempty (rempty),
    .sop    (out.sop),
    .eop    (out.eop)
  );

  bind buffer_bank_ctrl turbo_out_assertions u_bank_chk (
    .iclk   (iclk),
    .reset  (reset),
    .empty  (empty),
    .full   (full),
    .rempty (rempty),
    .sop    (1'b0),
    .eop    (1'b0)
  );

  initial begin
    iclk = 1'b0;
    forever #5 iclk = ~iclk;
  end

  // ------------------------------
  // reference and helpers
  // ------------------------------

  // word k holds bits 2k+1 down to 2k
  function automatic logic [nwords-1:0][turbo_out_pkg::rdat_w-1:0] pack_words(
    input logic [nbits-1:0] blk
  );
    logic [nwords-1:0][turbo_out_pkg::rdat_w-1:0] w;
    int k;
    for (k = 0; k < nwords; k++) begin
      w[k] = {blk[2*k+1], blk[2*k]};
    end
    return w;
  endfunction

  // local failures plus those of the bound checkers
  function automatic int error_count();
    return errors + dut.u_reader.u_reader_chk.fails
                  + dut.u_buffer.u_bank_ctrl.u_bank_chk.fails;
  endfunction

  task automatic write_block();
    logic [nbits-1:0]                             blk;
    logic [31:0]                                  rnd;
    logic [turbo_out_pkg::tag_w-1:0]              blk_tag;
    logic [nwords-1:0][turbo_out_pkg::rdat_w-1:0] ref_w;
    logic [turbo_out_pkg::addr_w-1:0]             fa;
    logic [turbo_out_pkg::addr_w-1:0]             ba;
    int i;
    int bi;
    blk     = {$urandom, $urandom};
    rnd     = $urandom;
    blk_tag = rnd[turbo_out_pkg::tag_w-1:0];
    ref_w   = pack_words(blk);
    for (i = 0; i < nwords; i++) begin
      exp_q.push_back('{valid: 1'b1, sop: (i == 0), eop: (i == nwords - 1),
                        data: ref_w[i], tag: blk_tag});
    end
    @(negedge iclk);
    while (full) @(negedge iclk);  // no new block on a full buffer
    for (i = 0; i < nwords; i++) begin
      bi = nbits - 1 - i;
      fa = i[turbo_out_pkg::addr_w-1:0];
      ba = bi[turbo_out_pkg::addr_w-1:0];
      @(posedge iclk);
      wr    <= '{write: 1'b1, faddr: fa, fbit: blk[i], baddr: ba, bbit: blk[bi]};
      wfull <= (i == nwords - 1);  // closes with the last pair
      wtag  <= blk_tag;
    end
    @(posedge iclk);
    wr.write <= 1'b0;
    wfull    <= 1'b0;
  endtask

  // expected flags for a given full-bank count
  task automatic check_flags(input int nfull);
    a_flags: assert (empty == (nfull == 0) && emptya == (nfull <= 1) &&
                     full == (nfull == nbanks) && fulla == (nfull >= nbanks - 1))
    else begin
      $display("FAILED at %0t: flags e %0b ea %0b f %0b fa %0b with %0d banks full",
               $time, empty, emptya, full, fulla, nfull);
      errors++;
    end
  endtask

  task automatic wait_drain(input string what);
    int n;
    n = 0;
    while ((exp_q.size() != 0 || !empty) && n < drain_limit) begin
      @(negedge iclk);
      n++;
    end
    a_drained: assert (exp_q.size() == 0) else begin
      $display("missing frame in %s: %0d expected words never came out", what, exp_q.size());
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (error_count() == errs_before) begin
      tests_ok++;
      $display("test %-10s ok", name);
    end else begin
      $display("test %-10s %0d errors", name, error_count() - errs_before);
    end
  endtask

  // ------------------------------
  // comparator
  // ------------------------------

  always @(negedge iclk) begin : compare_out
    turbo_out_pkg::out_word_t ew;
    if (out.valid) begin
      a_gate: assert (iclkena && !pause_d2) else begin
        $display("FAILED at %0t: valid word with clock enable low or under pause", $time);
        errors++;
      end
      a_extra: assert (exp_q.size() != 0) else begin
        $display("unexpected output word at %0t, no block is waiting to come out", $time);
        errors++;
      end
      if (exp_q.size() != 0) begin
        ew = exp_q.pop_front();
        checks++;
        a_word: assert (out === ew) else begin
          $display("FAILED at %0t: got d %0d s %0b e %0b tag %h, want d %0d s %0b e %0b tag %h",
                   $time, out.data, out.sop, out.eop, out.tag,
                   ew.data, ew.sop, ew.eop, ew.tag);
          errors++;
        end
      end
      wcnt = out.sop ? 1 : wcnt + 1;
      if (out.eop) begin
        frames++;
        a_len: assert (wcnt == nwords) else begin
          $display("FAILED at %0t: block closed after %0d words", $time, wcnt);
          errors++;
        end
      end
    end
    if (iclkena) begin  // pause history over enabled cycles only
      pause_d2 = pause_d1;
      pause_d1 = pause;
    end
  end

  // ------------------------------
  // tests
  // ------------------------------

  initial begin : run_tests
    int e0;
    int f0;
    int i;
    int r;
    int len;
    int guard;
    void'($urandom(32'h4a81));
    reset   = 1'b1;
    iclkena = 1'b1;
    wr      = '0;
    wfull   = 1'b0;
    wtag    = '0;
    pause   = 1'b0;
    repeat (3) @(posedge iclk);
    reset <= 1'b0;

    // 1 reset state with nothing written
    e0 = error_count();
    @(negedge iclk);
    check_flags(0);
    repeat (20) begin
      @(negedge iclk);
      a_quiet: assert (!out.valid) else begin
        $display("FAILED at %0t: valid word with an empty buffer", $time);
        errors++;
      end
    end
    report_test("reset", e0);

    // 2 data order over several blocks
    e0 = error_count();
    for (i = 0; i < 4; i++) write_block();
    wait_drain("data order");
    report_test("order", e0);

    // 3 framing and tags
    e0 = error_count();
    f0 = frames;
    for (i = 0; i < 3; i++) write_block();
    wait_drain("framing");
    a_frames: assert (frames - f0 == 3) else begin
      $display("FAILED at %0t: %0d frames seen, 3 written", $time, frames - f0);
      errors++;
    end
    report_test("framing", e0);

    // 4 bank flags as every bank fills under pause
    e0 = error_count();
    @(posedge iclk);
    pause <= 1'b1;
    for (i = 0; i < nbanks; i++) begin
      write_block();
      @(negedge iclk);
      check_flags(i + 1);  // fulla before full
    end
    @(posedge iclk);
    pause <= 1'b0;
    wait_drain("bank flags");
    check_flags(0);
    report_test("flags", e0);

    // 5 random clock enable and pause stretches during the drain
    e0 = error_count();
    @(posedge iclk);
    pause <= 1'b1;
    for (i = 0; i < nbanks; i++) write_block();
    guard = 0;
    while (exp_q.size() != 0 && guard < drain_limit) begin
      @(posedge iclk);
      r       = $urandom % 8;
      len     = 1 + $urandom % 4;
      iclkena <= (r > 1);   // low about a quarter of the time
      pause   <= (r == 2);
      repeat (len - 1) @(posedge iclk);  // hold the stretch
      guard += len;
    end
    @(posedge iclk);
    iclkena <= 1'b1;
    pause   <= 1'b0;
    wait_drain("stall");
    check_flags(0);
    report_test("stall", e0);

    $display("tests %0d, ok %0d, word checks %0d, errors %0d",
             tests_run, tests_ok, checks, error_count());
    if (error_count() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (wd_cycles) @(posedge iclk);
    $display("timeout after %0d cycles, the output stage stopped draining", wd_cycles);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

/* sources.f */
verilog/turbo_out_pkg.sv
verilog/buffer_bank_ctrl.sv
verilog/dec_output_ram.sv
verilog/turbo_dec_output_buffer.sv
verilog/block_reader.sv
verilog/turbo_out_top.sv
verif/turbo_out_assertions.sv
verif/tb_turbo_out.sv

/* Bender.yml */
package:
  name: turbo_out

sources:
  - verilog/turbo_out_pkg.sv
  - verilog/buffer_bank_ctrl.sv
  - verilog/dec_output_ram.sv
  - verilog/turbo_dec_output_buffer.sv
  - verilog/block_reader.sv
  - verilog/turbo_out_top.sv
  - target: test
    files:
      - verif/turbo_out_assertions.sv
      - verif/tb_turbo_out.sv
